//--- src/ahb_master_port_macros.svh
`ifndef AHB_MASTER_PORT_MACROS_SVH
`define AHB_MASTER_PORT_MACROS_SVH

// --------------------
// bus widths
// --------------------

`define AHB_ADDR_W      32
`define AHB_DATA_W      32

// slaves on the port
`define AHB_NUM_SLAVES  4

// large enough for 16-beat bursts
`define AHB_BEAT_CNT_W  4

// --------------------
// slave regions
// --------------------

// 256 MB per slave, top nibble decoded
`define AHB_SLV0_BASE   32'h0000_0000
`define AHB_SLV1_BASE   32'h1000_0000
`define AHB_SLV2_BASE   32'h2000_0000
`define AHB_SLV3_BASE   32'h3000_0000

`define AHB_SLV0_MASK   32'hF000_0000
`define AHB_SLV1_MASK   32'hF000_0000
`define AHB_SLV2_MASK   32'hF000_0000
`define AHB_SLV3_MASK   32'hF000_0000

// anything from 0x4000_0000 upward hits no region

`endif

//--- src/ahb_master_port_pkg.sv
`default_nettype none

`include "ahb_master_port_macros.svh"

package ahb_master_port_pkg;

    // transfer type, AHB encoding
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // burst type, AHB encoding
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_e;

    // only up to word on a 32-bit bus
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_e;

    // --------------------
    // phase bundles
    // --------------------

    typedef struct packed {
        logic [`AHB_ADDR_W-1:0] haddr;
        htrans_e                htrans;
        hburst_e                hburst;
        hsize_e                 hsize;
        logic                   hwrite;
    } ahb_addr_phase_t;

    typedef struct packed {
        logic [`AHB_DATA_W-1:0] hrdata;
        logic                   hreadyout;
        logic                   hresp;
    } ahb_slv_resp_t;

    // same layout, master side
    typedef struct packed {
        logic [`AHB_DATA_W-1:0] hrdata;
        logic                   hreadyout;
        logic                   hresp;
    } ahb_mst_resp_t;

endpackage

`default_nettype wire

//--- src/ahb_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_master_port_macros.svh"

module ahb_addr_decode (
    input  wire logic                                HCLK,
    input  wire logic                                HRESETn,
    input  wire ahb_master_port_pkg::ahb_addr_phase_t fwd_addr_i,
    input  wire logic                                hready_i,
    output logic [`AHB_NUM_SLAVES-1:0]               slv_sel_o,
    output logic [`AHB_NUM_SLAVES-1:0]               dphase_sel_o,
    output logic                                     dphase_write_o
);

    import ahb_master_port_pkg::*;

    // --------------------
    // region table
    // --------------------

    localparam logic [`AHB_ADDR_W-1:0] SLV_BASE [`AHB_NUM_SLAVES] = '{
        `AHB_SLV0_BASE,
        `AHB_SLV1_BASE,
        `AHB_SLV2_BASE,
        `AHB_SLV3_BASE
    };

    localparam logic [`AHB_ADDR_W-1:0] SLV_MASK [`AHB_NUM_SLAVES] = '{
        `AHB_SLV0_MASK,
        `AHB_SLV1_MASK,
        `AHB_SLV2_MASK,
        `AHB_SLV3_MASK
    };

    logic xfer_active;

    // --------------------
    // address phase decode
    // --------------------

    // regions do not overlap so at most one bit is set
    always_comb begin
        for (int i = 0; i < `AHB_NUM_SLAVES; i++) begin
            slv_sel_o[i] = ((fwd_addr_i.haddr & SLV_MASK[i]) ==
                            (SLV_BASE[i] & SLV_MASK[i]));
        end
    end

    // idle and busy phases carry no data phase
    assign xfer_active = (fwd_addr_i.htrans == NONSEQ) ||
                         (fwd_addr_i.htrans == SEQ);

    // --------------------
    // data phase owner
    // --------------------

    // one cycle behind the address phase
    // frozen while the current data phase is stalled
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            dphase_sel_o   <= '0;
            dphase_write_o <= 1'b0;
        end else if (hready_i) begin
            if (xfer_active) begin
                dphase_sel_o   <= slv_sel_o;
                dphase_write_o <= fwd_addr_i.hwrite;
            end else begin
                dphase_sel_o   <= '0;
                dphase_write_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ahb_burst_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_master_port_macros.svh"

module ahb_burst_addr_gen (
    input  wire logic                                HCLK,
    input  wire logic                                HRESETn,
    input  wire ahb_master_port_pkg::ahb_addr_phase_t mst_addr_i,
    input  wire logic                                hready_i,
    output ahb_master_port_pkg::ahb_addr_phase_t     fwd_addr_o
);

    import ahb_master_port_pkg::*;

    typedef logic [`AHB_ADDR_W-1:0]     addr_t;
    typedef logic [`AHB_BEAT_CNT_W-1:0] cnt_t;

    logic  is_single;
    logic  is_incr_undef;
    logic  is_wrap;
    cnt_t  beats_m1;
    logic  [1:0] size_shift;
    addr_t addr_incr;
    addr_t wrap_mask;

    cnt_t  beat_cnt;
    logic  seq_seen;
    logic  cnt_exhausted;
    addr_t next_addr;

    logic  use_gen;
    addr_t cur_addr;
    addr_t succ_incr;
    addr_t succ_addr;
    logic  accept_nonseq;
    logic  accept_seq;

    // --------------------
    // burst and size decode
    // --------------------

    assign is_single     = (mst_addr_i.hburst == SINGLE);
    assign is_incr_undef = (mst_addr_i.hburst == INCR);
    assign is_wrap       = (mst_addr_i.hburst == WRAP4) ||
                           (mst_addr_i.hburst == WRAP8) ||
                           (mst_addr_i.hburst == WRAP16);

    // beats minus one
    always_comb begin
        case (mst_addr_i.hburst)
            WRAP4, INCR4:   beats_m1 = cnt_t'(3);
            WRAP8, INCR8:   beats_m1 = cnt_t'(7);
            WRAP16, INCR16: beats_m1 = cnt_t'(15);
            default:        beats_m1 = '0;
        endcase
    end

    // log2 of the transfer size in bytes
    always_comb begin
        case (mst_addr_i.hsize)
            BYTE:    size_shift = 2'd0;
            HALF:    size_shift = 2'd1;
            default: size_shift = 2'd2;
        endcase
    end

    assign addr_incr = addr_t'(1) << size_shift;

    // wrap boundary is beats times size bytes
    assign wrap_mask = ((addr_t'(beats_m1) + addr_t'(1)) << size_shift) - addr_t'(1);

    // --------------------
    // address select
    // --------------------

    // undefined length INCR never runs out
    assign cnt_exhausted = !is_single && !is_incr_undef && seq_seen &&
                           (beat_cnt == '0);

    assign use_gen = ((mst_addr_i.htrans == SEQ) || (mst_addr_i.htrans == BUSY)) &&
                     !is_single && !cnt_exhausted;

    assign cur_addr = use_gen ? next_addr : mst_addr_i.haddr;

    // upper bits kept, low bits roll over inside the boundary
    assign succ_incr = cur_addr + addr_incr;
    assign succ_addr = is_wrap ? ((cur_addr & ~wrap_mask) | (succ_incr & wrap_mask))
                               : succ_incr;

    always_comb begin
        fwd_addr_o       = mst_addr_i;
        fwd_addr_o.haddr = cur_addr;
    end

    // --------------------
    // beat counter and next address
    // --------------------

    assign accept_nonseq = hready_i && (mst_addr_i.htrans == NONSEQ);
    assign accept_seq    = hready_i && (mst_addr_i.htrans == SEQ);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            beat_cnt  <= '0;
            seq_seen  <= 1'b0;
            next_addr <= '0;
        end else if (accept_nonseq) begin
            beat_cnt  <= beats_m1;
            seq_seen  <= 1'b0;
            next_addr <= succ_addr;
        end else if (accept_seq) begin
            // stop at zero so an overrun stays exhausted
            if (!is_incr_undef && (beat_cnt != '0)) begin
                beat_cnt <= beat_cnt - cnt_t'(1);
            end
            seq_seen  <= 1'b1;
            next_addr <= succ_addr;
        end
    end

endmodule

`default_nettype wire

//--- src/ahb_resp_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_master_port_macros.svh"

module ahb_resp_mux (
    input  wire logic [`AHB_NUM_SLAVES-1:0]           dphase_sel_i,
    input  wire logic                                 dphase_write_i,
    input  wire logic [`AHB_DATA_W-1:0]               mst_hwdata_i,
    input  wire ahb_master_port_pkg::ahb_slv_resp_t   slv_resp_i [`AHB_NUM_SLAVES],
    output logic [`AHB_DATA_W-1:0]                    slv_hwdata_o [`AHB_NUM_SLAVES],
    output ahb_master_port_pkg::ahb_mst_resp_t        mst_resp_o
);

    logic [`AHB_DATA_W-1:0] rdata_sel;
    logic                   ready_sel;
    logic                   resp_sel;

    // --------------------
    // write data steering
    // --------------------

    // only the data phase owner sees hwdata
    always_comb begin
        for (int i = 0; i < `AHB_NUM_SLAVES; i++) begin
            slv_hwdata_o[i] = dphase_sel_i[i] ? mst_hwdata_i : '0;
        end
    end

    // --------------------
    // response select
    // --------------------

    // no owner looks like an idle, ready slave
    always_comb begin
        rdata_sel = '0;
        ready_sel = 1'b1;
        resp_sel  = 1'b0;
        for (int i = 0; i < `AHB_NUM_SLAVES; i++) begin
            if (dphase_sel_i[i]) begin
                rdata_sel = slv_resp_i[i].hrdata;
                ready_sel = slv_resp_i[i].hreadyout;
                resp_sel  = slv_resp_i[i].hresp;
            end
        end
    end

    // read data is meaningless on a write data phase
    always_comb begin
        mst_resp_o.hrdata    = dphase_write_i ? '0 : rdata_sel;
        mst_resp_o.hreadyout = ready_sel;
        mst_resp_o.hresp     = resp_sel;
    end

endmodule

`default_nettype wire

//--- src/ahb_master_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_master_port_macros.svh"

module ahb_master_port (
    input  wire logic                                 HCLK,
    input  wire logic                                 HRESETn,

    // master side
    input  wire ahb_master_port_pkg::ahb_addr_phase_t mst_addr_i,
    input  wire logic [`AHB_DATA_W-1:0]               mst_hwdata_i,
    output ahb_master_port_pkg::ahb_mst_resp_t        mst_resp_o,

    // slave side
    output logic [`AHB_NUM_SLAVES-1:0]                slv_sel_o,
    output ahb_master_port_pkg::ahb_addr_phase_t      slv_addr_o,
    output logic [`AHB_DATA_W-1:0]                    slv_hwdata_o [`AHB_NUM_SLAVES],
    input  wire ahb_master_port_pkg::ahb_slv_resp_t   slv_resp_i [`AHB_NUM_SLAVES]
);

    import ahb_master_port_pkg::*;

    ahb_addr_phase_t             fwd_addr;
    logic [`AHB_NUM_SLAVES-1:0]  dphase_sel;
    logic                        dphase_write;

    // --------------------
    // address phase
    // --------------------

    // generated SEQ addresses replace the master's haddr
    ahb_burst_addr_gen u_burst_addr_gen (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .mst_addr_i (mst_addr_i),
        .hready_i   (mst_resp_o.hreadyout),
        .fwd_addr_o (fwd_addr)
    );

    // broadcast to every slave
    assign slv_addr_o = fwd_addr;

    ahb_addr_decode u_addr_decode (
        .HCLK           (HCLK),
        .HRESETn        (HRESETn),
        .fwd_addr_i     (fwd_addr),
        .hready_i       (mst_resp_o.hreadyout),
        .slv_sel_o      (slv_sel_o),
        .dphase_sel_o   (dphase_sel),
        .dphase_write_o (dphase_write)
    );

    // --------------------
    // data phase
    // --------------------

    ahb_resp_mux u_resp_mux (
        .dphase_sel_i   (dphase_sel),
        .dphase_write_i (dphase_write),
        .mst_hwdata_i   (mst_hwdata_i),
        .slv_resp_i     (slv_resp_i),
        .slv_hwdata_o   (slv_hwdata_o),
        .mst_resp_o     (mst_resp_o)
    );

endmodule

`default_nettype wire

//--- tests/ahb_master_port_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_master_port_macros.svh"

module ahb_master_port_properties (
    input  wire logic                               HCLK,
    input  wire logic                               HRESETn,
    input  wire logic [`AHB_NUM_SLAVES-1:0]         slv_sel_i,
    input  wire logic [`AHB_NUM_SLAVES-1:0]         dphase_sel_i,
    input  wire logic                               dphase_write_i,
    input  wire logic                               hready_i,
    input  wire ahb_master_port_pkg::ahb_mst_resp_t mst_resp_i
);

    // regions are disjoint
    sel_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
        $onehot0(slv_sel_i))
        else $error("slave select is neither one-hot nor zero");

    // a stalled data phase keeps its owner
    dphase_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
        !hready_i |=> $stable(dphase_sel_i))
        else $error("data phase select changed during a wait state");

    rdata_zero_on_write: assert property (@(posedge HCLK) disable iff (!HRESETn)
        dphase_write_i |-> (mst_resp_i.hrdata == '0))
        else $error("read data not zero on a write data phase");

endmodule

// decode and response mux outputs, as wired in the top level
bind ahb_master_port ahb_master_port_properties u_properties (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .slv_sel_i      (slv_sel_o),
    .dphase_sel_i   (dphase_sel),
    .dphase_write_i (dphase_write),
    .hready_i       (mst_resp_o.hreadyout),
    .mst_resp_i     (mst_resp_o)
);

`default_nettype wire

//--- tests/ahb_master_port_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ahb_master_port_macros.svh"

module ahb_master_port_tb;

    import ahb_master_port_pkg::*;

    // one row per clock cycle
    typedef struct packed {
        logic [2:0]                 test_id;
        htrans_e                    htrans;
        hburst_e                    hburst;
        hsize_e                     hsize;
        logic [`AHB_ADDR_W-1:0]     haddr;
        logic                       hwrite;
        logic                       ready;
        logic [`AHB_NUM_SLAVES-1:0] exp_sel;
        logic [`AHB_ADDR_W-1:0]     exp_haddr;
        logic [`AHB_NUM_SLAVES-1:0] exp_dsel;
        logic [`AHB_DATA_W-1:0]     exp_rdata;
        logic                       exp_ready;
    } row_t;

    // read data of slaves 1 to 3, slave 0 returns zero
    localparam logic [`AHB_DATA_W-1:0] RD1 = 32'h1111_1111;
    localparam logic [`AHB_DATA_W-1:0] RD2 = 32'h2222_2222;
    localparam logic [`AHB_DATA_W-1:0] RD3 = 32'h3333_3333;

    logic                       HCLK = 1'b0;
    logic                       HRESETn;
    ahb_addr_phase_t            mst_addr;
    logic [`AHB_DATA_W-1:0]     mst_hwdata;
    ahb_mst_resp_t              mst_resp;
    logic [`AHB_NUM_SLAVES-1:0] slv_sel;
    ahb_addr_phase_t            slv_addr;
    logic [`AHB_DATA_W-1:0]     slv_hwdata [`AHB_NUM_SLAVES];
    ahb_slv_resp_t              slv_resp [`AHB_NUM_SLAVES];
    logic                       slv_ready;

    row_t rows [$];
    int   errors;
    int   checks;
    int   cur_test;
    int   test_errs [8] = '{default: 0};

    ahb_master_port ahb_master_port_inst (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .mst_addr_i   (mst_addr),
        .mst_hwdata_i (mst_hwdata),
        .mst_resp_o   (mst_resp),
        .slv_sel_o    (slv_sel),
        .slv_addr_o   (slv_addr),
        .slv_hwdata_o (slv_hwdata),
        .slv_resp_i   (slv_resp)
    );

    always #20 HCLK = ~HCLK;

    // --------------------
    // slave models
    // --------------------

    always_comb begin
        for (int i = 0; i < `AHB_NUM_SLAVES; i++) begin
            slv_resp[i].hrdata    = 32'(i) * 32'h1111_1111;
            slv_resp[i].hreadyout = slv_ready;
            slv_resp[i].hresp     = 1'b0;
        end
    end

    task automatic add_row(input int t, input htrans_e tr, input hburst_e hb, input hsize_e hs,
                           input logic [`AHB_ADDR_W-1:0] a, input int w, input int rdy,
                           input logic [3:0] es, input logic [`AHB_ADDR_W-1:0] ea,
                           input logic [3:0] ed, input logic [`AHB_DATA_W-1:0] er,
                           input int erdy);
        rows.push_back(row_t'{3'(t), tr, hb, hs, a, 1'(w), 1'(rdy), es, ea, ed, er, 1'(erdy)});
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errs[cur_test]++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    initial begin
        int                     wait_cnt;
        logic [`AHB_DATA_W-1:0] wdata;
        row_t                   row;

        void'($urandom(41));
        HRESETn    = 1'b0;
        mst_addr   = '{haddr: '0, htrans: IDLE, hburst: SINGLE, hsize: WORD, hwrite: 1'b0};
        mst_hwdata = '0;
        slv_ready  = 1'b1;
        errors     = 0;
        checks     = 0;
        cur_test   = 0;
        wait_cnt   = 0;

        // --------------------
        // stimulus table
        // --------------------

        // decode of every region, then an unmapped address
        add_row(1, NONSEQ, SINGLE, WORD, 'h00000100, 0, 1, 4'h1, 'h00000100, 4'h0, '0, 1);
        add_row(1, NONSEQ, SINGLE, WORD, 'h10000200, 0, 1, 4'h2, 'h10000200, 4'h1, '0, 1);
        add_row(1, NONSEQ, SINGLE, WORD, 'h20000300, 0, 1, 4'h4, 'h20000300, 4'h2, RD1, 1);
        add_row(1, NONSEQ, SINGLE, WORD, 'h30000400, 0, 1, 4'h8, 'h30000400, 4'h4, RD2, 1);
        add_row(1, NONSEQ, SINGLE, WORD, 'h40000000, 0, 1, 4'h0, 'h40000000, 4'h8, RD3, 1);
        add_row(1, IDLE,   SINGLE, WORD, 'h80000000, 0, 0, 4'h0, 'h80000000, 4'h0, '0, 1);
        // INCR4, master haddr ignored until the count runs out
        add_row(2, NONSEQ, INCR4, WORD, 'h10000010, 0, 1, 4'h2, 'h10000010, 4'h0, '0, 1);
        add_row(2, SEQ,    INCR4, WORD, 'h10000F00, 0, 1, 4'h2, 'h10000014, 4'h2, RD1, 1);
        add_row(2, SEQ,    INCR4, WORD, 'h10000F00, 0, 1, 4'h2, 'h10000018, 4'h2, RD1, 1);
        add_row(2, SEQ,    INCR4, WORD, 'h10000F00, 0, 1, 4'h2, 'h1000001C, 4'h2, RD1, 1);
        add_row(2, SEQ,    INCR4, WORD, 'h10000F40, 0, 1, 4'h2, 'h10000F40, 4'h2, RD1, 1);
        // WRAP4 words, then WRAP8 halfwords, both in 16 bytes
        add_row(3, NONSEQ, WRAP4, WORD, 'h20000038, 0, 1, 4'h4, 'h20000038, 4'h2, RD1, 1);
        add_row(3, SEQ,    WRAP4, WORD, 'h20000000, 0, 1, 4'h4, 'h2000003C, 4'h4, RD2, 1);
        add_row(3, SEQ,    WRAP4, WORD, 'h20000000, 0, 1, 4'h4, 'h20000030, 4'h4, RD2, 1);
        add_row(3, SEQ,    WRAP4, WORD, 'h20000000, 0, 1, 4'h4, 'h20000034, 4'h4, RD2, 1);
        add_row(3, NONSEQ, WRAP8, HALF, 'h20000006, 0, 1, 4'h4, 'h20000006, 4'h4, RD2, 1);
        add_row(3, SEQ,    WRAP8, HALF, 'h20000000, 0, 1, 4'h4, 'h20000008, 4'h4, RD2, 1);
        add_row(3, SEQ,    WRAP8, HALF, 'h20000000, 0, 1, 4'h4, 'h2000000A, 4'h4, RD2, 1);
        add_row(3, SEQ,    WRAP8, HALF, 'h20000000, 0, 1, 4'h4, 'h2000000C, 4'h4, RD2, 1);
        add_row(3, SEQ,    WRAP8, HALF, 'h20000000, 0, 1, 4'h4, 'h2000000E, 4'h4, RD2, 1);
        add_row(3, SEQ,    WRAP8, HALF, 'h20000000, 0, 1, 4'h4, 'h20000000, 4'h4, RD2, 1);
        // wait states in the middle of the WRAP8
        add_row(4, SEQ,    WRAP8, HALF, 'h20000000, 0, 0, 4'h4, 'h20000002, 4'h4, RD2, 0);
        add_row(4, SEQ,    WRAP8, HALF, 'h20000000, 0, 0, 4'h4, 'h20000002, 4'h4, RD2, 0);
        add_row(4, SEQ,    WRAP8, HALF, 'h20000000, 0, 1, 4'h4, 'h20000002, 4'h4, RD2, 1);
        add_row(4, SEQ,    WRAP8, HALF, 'h20000000, 0, 1, 4'h4, 'h20000004, 4'h4, RD2, 1);
        // last beat stalled while the next address goes to slave 1
        add_row(4, NONSEQ, SINGLE, WORD, 'h10000100, 0, 0, 4'h2, 'h10000100, 4'h4, RD2, 0);
        add_row(4, NONSEQ, SINGLE, WORD, 'h10000100, 0, 0, 4'h2, 'h10000100, 4'h4, RD2, 0);
        add_row(4, NONSEQ, SINGLE, WORD, 'h10000100, 0, 1, 4'h2, 'h10000100, 4'h4, RD2, 1);
        // write to slave 3, read data from slave 1 while slave 3 is addressed
        add_row(5, NONSEQ, SINGLE, WORD, 'h30000040, 1, 1, 4'h8, 'h30000040, 4'h2, RD1, 1);
        add_row(5, NONSEQ, SINGLE, WORD, 'h10000080, 0, 1, 4'h2, 'h10000080, 4'h8, '0, 1);
        add_row(5, NONSEQ, SINGLE, WORD, 'h30000044, 0, 1, 4'h8, 'h30000044, 4'h2, RD1, 1);
        add_row(5, IDLE,   SINGLE, WORD, 'h00000000, 0, 1, 4'h1, 'h00000000, 4'h8, RD3, 1);

        repeat (16) @(posedge HCLK);
        #2;
        HRESETn = 1'b1;
        while (mst_resp.hreadyout !== 1'b1 && wait_cnt < 8) begin
            @(posedge HCLK);
            wait_cnt++;
        end

        if (mst_resp.hreadyout !== 1'b1) begin
            $display("Timeout: hreadyout did not go high after reset release");
            $display("TESTS FAILED");
            $finish;
        end else begin
            for (int r = 0; r < rows.size(); r++) begin
                row = rows[r];
                @(posedge HCLK);
                #2;
                wdata           = $urandom;
                cur_test        = int'(row.test_id);
                mst_addr.haddr  = row.haddr;
                mst_addr.htrans = row.htrans;
                mst_addr.hburst = row.hburst;
                mst_addr.hsize  = row.hsize;
                mst_addr.hwrite = row.hwrite;
                mst_hwdata      = wdata;
                slv_ready       = row.ready;
                // sample just before the next rising edge
                #36;
                check_value("slv_sel_o", 32'(row.exp_sel), 32'(slv_sel));
                check_value("slv_addr_o.haddr", row.exp_haddr, slv_addr.haddr);
                check_value("slv_addr_o.{htrans,hburst,hsize,hwrite}",
                            32'({row.htrans, row.hburst, row.hsize, row.hwrite}),
                            32'({slv_addr.htrans, slv_addr.hburst, slv_addr.hsize,
                                 slv_addr.hwrite}));
                check_value("mst_resp_o.hrdata", row.exp_rdata, mst_resp.hrdata);
                check_value("mst_resp_o.hreadyout", 32'(row.exp_ready), 32'(mst_resp.hreadyout));
                check_value("mst_resp_o.hresp", 32'h0, 32'(mst_resp.hresp));
                for (int i = 0; i < `AHB_NUM_SLAVES; i++) begin
                    check_value($sformatf("slv_hwdata_o[%0d]", i),
                                row.exp_dsel[i] ? wdata : 32'h0, slv_hwdata[i]);
                end
                if (r == rows.size() - 1 || rows[r + 1].test_id != row.test_id) begin
                    $display("test %0d finished with %0d errors", cur_test, test_errs[cur_test]);
                end
            end
            $display("%0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- ahb_master_port.f
+incdir+src
src/ahb_master_port_pkg.sv
src/ahb_addr_decode.sv
src/ahb_burst_addr_gen.sv
src/ahb_resp_mux.sv
src/ahb_master_port.sv
tests/ahb_master_port_properties.sv
tests/ahb_master_port_tb.sv
